//--- hdl/exPkg.sv
// Shared widths, ALU codes and pipeline bundle types for the execute stage and its testbench
`default_nettype none

package exPkg;

    localparam int XLEN       = 32;                  // Data and PC width
    localparam int REG_ADDR_W = 5;                   // Register index width

    localparam logic [2:0]      FUNCT3_BEQ = 3'b000; // Branch if equal
    localparam logic [2:0]      FUNCT3_BNE = 3'b001; // Branch if not equal
    localparam logic [XLEN-1:0] PC_STEP    = 32'd4;  // Link offset for jumps

    // Decode class from the control unit
    typedef enum logic [1:0] {
        memAdd    = 2'b00,                           // Loads and stores, address add
        branchSub = 2'b01,                           // Branch compare by subtraction
        regType   = 2'b10,                           // R-type, funct7 selects variants
        immType   = 2'b11                            // I-type, funct7 only for shifts
    } aluOpE;

    // Operation performed by the ALU
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,                                 // Arithmetic shift keeps the sign
        SLT  = 4'd8,                                 // Signed compare
        SLTU = 4'd9                                  // Unsigned compare
    } aluCtrlE;

    // Operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        none      = 2'b00,                           // Register file value
        fromExMem = 2'b10,                           // Result still in EX/MEM
        fromMemWb = 2'b01                            // Value being written back
    } fwdSelE;

    // Decoded control bits carried with the instruction
    typedef struct packed {
        logic  aluSrc;                               // Operand B from immediate
        aluOpE aluOp;
        logic  branch;
        logic  jump;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  regWrite;
    } ctrlT;

    // ID/EX register contents
    typedef struct packed {
        logic                  enable;               // Slot holds a valid instruction
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       readData1;
        logic [XLEN-1:0]       readData2;
        logic [XLEN-1:0]       immediate;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            funct7;
        logic [2:0]            funct3;
        ctrlT                  ctrl;
    } idExT;

    // EX/MEM register contents
    typedef struct packed {
        logic                  enable;               // Next stage may proceed
        logic [XLEN-1:0]       pc;                   // Redirect target or own PC
        logic [XLEN-1:0]       aluResult;            // ALU output or link value
        logic [XLEN-1:0]       writeData;            // Store data, forwarded
        logic [REG_ADDR_W-1:0] rd;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
        logic                  regWrite;
    } exMemT;

    // MEM/WB write-back seen by forwarding
    typedef struct packed {
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wbFwdT;

endpackage

`default_nettype wire

//--- hdl/aluDecoder.sv
// Combinational ALU operation decoder, instantiated by the execute stage
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
    input  wire exPkg::aluOpE   aluOp,              // Decode class from control
    input  wire logic [2:0]     funct3,             // Instruction funct3 field
    input  wire logic [6:0]     funct7,             // Instruction funct7 field
    output exPkg::aluCtrlE      aluCtrl             // Operation for the ALU
);

    import exPkg::*;

    logic altBit;                                   // funct7 bit 5, alternate encoding
    logic subAllowed;                               // Only R-type may turn ADD into SUB

    assign altBit     = funct7[5];
    assign subAllowed = (aluOp == regType);

    always_comb begin
        aluCtrl = ADD;                              // Safe default
        case (aluOp)
            memAdd: begin
                aluCtrl = ADD;                      // Effective address
            end
            branchSub: begin
                aluCtrl = SUB;                      // Zero flag gives equality
            end
            regType, immType: begin
                // Same funct3 map for both classes
                case (funct3)
                    3'b000: aluCtrl = (subAllowed && altBit) ? SUB : ADD; // ADDI stays ADD
                    3'b001: aluCtrl = SLL;
                    3'b010: aluCtrl = SLT;
                    3'b011: aluCtrl = SLTU;
                    3'b100: aluCtrl = XOR;
                    3'b101: aluCtrl = altBit ? SRA : SRL;  // SRAI and SRA share bit 5
                    3'b110: aluCtrl = OR;
                    3'b111: aluCtrl = AND;
                    default: aluCtrl = ADD;
                endcase
            end
            default: begin
                aluCtrl = ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
// Combinational 32-bit integer ALU with zero flag, used by the execute stage
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire exPkg::aluCtrlE       aluCtrl,      // Operation select
    input  wire logic [31:0]          a,            // Operand A
    input  wire logic [31:0]          b,            // Operand B
    output logic [31:0]               result,       // Operation result
    output logic                      zero          // High when result is zero
);

    import exPkg::*;

    logic [4:0] shamt;                              // Shift amount, low five bits of b
    logic       ltSigned;                           // Signed less-than
    logic       ltUnsigned;                         // Unsigned less-than

    assign shamt      = b[4:0];
    assign ltSigned   = ($signed(a) < $signed(b));
    assign ltUnsigned = (a < b);

    always_comb begin
        case (aluCtrl)
            ADD:  result = a + b;
            SUB:  result = a - b;
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            SLL:  result = a << shamt;
            SRL:  result = a >> shamt;                     // Zero fill
            SRA:  result = $unsigned($signed(a) >>> shamt); // Sign fill
            SLT:  result = {31'b0, ltSigned};
            SLTU: result = {31'b0, ltUnsigned};
            default: begin
                result = '0;                        // Unused codes
            end
        endcase
    end

    // Branch compare relies on SUB result being zero
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/forwardUnit.sv
// Operand forwarding selector that compares sources with in-flight destinations for the execute unit
`timescale 1ns/1ns
`default_nettype none

module forwardUnit (
    input  wire logic [exPkg::REG_ADDR_W-1:0] rs1,           // Source register A
    input  wire logic [exPkg::REG_ADDR_W-1:0] rs2,           // Source register B
    input  wire logic [exPkg::REG_ADDR_W-1:0] exMemRd,       // Destination in EX/MEM
    input  wire logic                         exMemRegWrite, // EX/MEM will write rd
    input  wire logic                         exMemEnable,   // EX/MEM slot is live
    input  wire exPkg::wbFwdT                 memWb,         // Write-back in progress
    output exPkg::fwdSelE                     fwdA,          // Source for operand A
    output exPkg::fwdSelE                     fwdB           // Source for register B value
);

    import exPkg::*;

    logic exMemLive;                                // EX/MEM can supply a value
    logic memWbLive;                                // MEM/WB can supply a value

    // Pick a source for one register with the newest producer first
    function automatic fwdSelE pickSource(
        input logic [REG_ADDR_W-1:0] rs,            // Source register to resolve
        input logic                  exLive,        // EX/MEM can supply a value
        input logic [REG_ADDR_W-1:0] exRd,          // EX/MEM destination
        input logic                  wbLive,        // MEM/WB can supply a value
        input logic [REG_ADDR_W-1:0] wbRd           // MEM/WB destination
    );
        fwdSelE sel;
        sel = none;
        if (exLive && (exRd == rs)) begin
            sel = fromExMem;                        // Youngest result wins
        end else if (wbLive && (wbRd == rs)) begin
            sel = fromMemWb;
        end
        return sel;
    endfunction

    // x0 is hardwired so it never forwards
    assign exMemLive = exMemEnable && exMemRegWrite && (exMemRd != '0);
    assign memWbLive = memWb.regWrite && (memWb.rd != '0);

    assign fwdA = pickSource(rs1, exMemLive, exMemRd, memWbLive, memWb.rd);
    assign fwdB = pickSource(rs2, exMemLive, exMemRd, memWbLive, memWb.rd);

endmodule

`default_nettype wire

//--- hdl/exStage.sv
// Execute stage datapath, branch resolution and EX/MEM register, used inside the execute unit
`timescale 1ns/1ns
`default_nettype none

module exStage (
    input  wire logic                   clk,
    input  wire logic                   reset_n,    // Asynchronous, active low
    input  wire exPkg::idExT            idEx,       // Instruction from ID/EX
    input  wire exPkg::fwdSelE          fwdA,       // Operand A source
    input  wire exPkg::fwdSelE          fwdB,       // Register B source
    input  wire logic [exPkg::XLEN-1:0] memWbData,  // Value being written back
    input  wire logic                   stall,      // Combined pipeline stall
    input  wire logic                   memStall,   // Stall raised by MEM
    output exPkg::exMemT                exMem,      // EX/MEM register
    output logic                        clearIfId   // Flush IF/ID after redirect
);

    import exPkg::*;

    aluCtrlE         aluCtrl;                       // Decoded ALU operation
    logic [XLEN-1:0] opA;                           // ALU operand A
    logic [XLEN-1:0] regB;                          // Forwarded rs2 value
    logic [XLEN-1:0] opB;                           // ALU operand B
    logic [XLEN-1:0] aluOut;
    logic            aluZero;
    logic            branchTaken;                   // Conditional branch resolves taken
    logic            redirect;                      // Control flow changes
    logic [XLEN-1:0] target;                        // Branch and jump target
    exMemT           nextExMem;                     // Bundle for an accepted instruction

    aluDecoder uDecoder (
        .aluOp   (idEx.ctrl.aluOp),
        .funct3  (idEx.funct3),
        .funct7  (idEx.funct7),
        .aluCtrl (aluCtrl)
    );

    // Forwarding muxes, EX/MEM result is the own registered output
    always_comb begin
        case (fwdA)
            fromExMem: opA = exMem.aluResult;
            fromMemWb: opA = memWbData;
            default:   opA = idEx.readData1;
        endcase
        case (fwdB)
            fromExMem: regB = exMem.aluResult;
            fromMemWb: regB = memWbData;
            default:   regB = idEx.readData2;
        endcase
    end

    assign opB = idEx.ctrl.aluSrc ? idEx.immediate : regB; // Immediate or register

    alu uAlu (
        .aluCtrl (aluCtrl),
        .a       (opA),
        .b       (opB),
        .result  (aluOut),
        .zero    (aluZero)
    );

    // Only BEQ and BNE are resolved here
    always_comb begin
        branchTaken = 1'b0;
        if (idEx.ctrl.branch) begin
            case (idEx.funct3)
                FUNCT3_BEQ: branchTaken = aluZero;
                FUNCT3_BNE: branchTaken = !aluZero;
                default:    branchTaken = 1'b0;
            endcase
        end
    end

    assign redirect = idEx.ctrl.jump || branchTaken;
    assign target   = idEx.pc + (idEx.immediate << 1); // Halfword-scaled offset

    always_comb begin
        nextExMem           = '0;
        nextExMem.enable    = 1'b1;
        nextExMem.pc        = redirect ? target : idEx.pc;
        nextExMem.aluResult = idEx.ctrl.jump ? (idEx.pc + PC_STEP) : aluOut; // Link value
        nextExMem.writeData = regB;                 // Store data also forwarded
        nextExMem.rd        = idEx.rd;
        nextExMem.memRead   = idEx.ctrl.memRead;
        nextExMem.memWrite  = idEx.ctrl.memWrite;
        nextExMem.memToReg  = idEx.ctrl.memToReg;
        nextExMem.regWrite  = idEx.ctrl.regWrite;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exMem     <= '0;
            clearIfId <= 1'b0;
        end else if (stall) begin
            exMem        <= '0;                     // Bubble
            exMem.enable <= memStall;               // Let MEM finish its own stall
            clearIfId    <= 1'b0;
        end else if (idEx.enable) begin
            exMem     <= nextExMem;                 // Accept instruction
            clearIfId <= redirect;                  // One-cycle flush pulse
        end else begin
            exMem.enable <= 1'b0;                   // Idle, payload holds
            clearIfId    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
// Execute subsystem top, joins forwarding and execute stage for standalone testing
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
    input  wire logic         clk,
    input  wire logic         reset_n,              // Asynchronous, active low
    input  wire exPkg::idExT  idEx,                 // From decode stage
    input  wire exPkg::wbFwdT memWb,                // From write-back
    input  wire logic         stall,                // Combined stall
    input  wire logic         memStall,             // Stall comes from MEM
    output exPkg::exMemT      exMem,                // EX/MEM bundle
    output logic              clearIfId             // Flush request for IF/ID
);

    import exPkg::*;

    fwdSelE fwdA;                                   // Operand A source
    fwdSelE fwdB;                                   // Register B source

    // Registered EX/MEM output loops back for forwarding
    forwardUnit uForward (
        .rs1           (idEx.rs1),
        .rs2           (idEx.rs2),
        .exMemRd       (exMem.rd),
        .exMemRegWrite (exMem.regWrite),
        .exMemEnable   (exMem.enable),
        .memWb         (memWb),
        .fwdA          (fwdA),
        .fwdB          (fwdB)
    );

    exStage uExStage (
        .clk       (clk),
        .reset_n   (reset_n),
        .idEx      (idEx),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .memWbData (memWb.data),
        .stall     (stall),
        .memStall  (memStall),
        .exMem     (exMem),
        .clearIfId (clearIfId)
    );

endmodule

`default_nettype wire

//--- verif/exModel.svh
// Reference model of ALU decode, forwarding and branch rules, included inside the execute testbench
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// Result of one operation, straight from the RV32I definitions
function automatic logic [31:0] aluModel(input aluOpE aluOp, input logic [2:0] funct3,
                                         input logic [6:0] funct7, input logic [31:0] a,
                                         input logic [31:0] b);
    logic [63:0] signExt;                           // Sign-extended A for arithmetic shift
    logic [4:0]  sh;
    logic        altBit;
    sh      = b[4:0];
    altBit  = funct7[5];
    signExt = {{32{a[31]}}, a} >> sh;
    if (aluOp == memAdd) return a + b;              // Address add
    if (aluOp == branchSub) return a - b;           // Compare by subtraction
    if (funct3 == 3'b000) return (aluOp == regType && altBit) ? a - b : a + b;
    if (funct3 == 3'b001) return a << sh;
    if (funct3 == 3'b010) return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
    if (funct3 == 3'b011) return {31'b0, a < b};    // Unsigned compare
    if (funct3 == 3'b100) return a ^ b;
    if (funct3 == 3'b101) return altBit ? signExt[31:0] : a >> sh;
    if (funct3 == 3'b110) return a | b;
    return a & b;
endfunction

// Register value after forwarding, youngest live producer first
function automatic logic [31:0] forwardModel(input logic [4:0] rs, input logic [31:0] regValue,
                                             input exMemT last, input wbFwdT wb);
    if (rs == 5'd0) return regValue;                // x0 never forwards
    if (last.enable && last.regWrite && last.rd == rs) return last.aluResult;
    if (wb.regWrite && wb.rd == rs) return wb.data;
    return regValue;
endfunction

// Next EX/MEM bundle and flush bit for one clock edge
function automatic exMemT stepModel(input idExT id, input wbFwdT wb, input logic stall,
                                    input logic memStall, input exMemT last,
                                    output logic clear);
    exMemT       nxt;
    logic [31:0] opA;
    logic [31:0] regB;
    logic [31:0] opB;
    logic        taken;
    opA   = forwardModel(id.rs1, id.readData1, last, wb);
    regB  = forwardModel(id.rs2, id.readData2, last, wb);
    opB   = id.ctrl.aluSrc ? id.immediate : regB;
    taken = id.ctrl.jump ||
            (id.ctrl.branch && ((id.funct3 == FUNCT3_BEQ && opA == opB) ||
                                (id.funct3 == FUNCT3_BNE && opA != opB)));
    clear = 1'b0;
    if (stall) begin
        nxt        = '0;                            // Bubble
        nxt.enable = memStall;
    end else if (!id.enable) begin
        nxt        = last;                          // Idle keeps payload
        nxt.enable = 1'b0;
    end else begin
        nxt           = '0;
        nxt.enable    = 1'b1;
        nxt.pc        = taken ? id.pc + {id.immediate[30:0], 1'b0} : id.pc;
        nxt.aluResult = id.ctrl.jump ? id.pc + 32'd4 :
                        aluModel(id.ctrl.aluOp, id.funct3, id.funct7, opA, opB);
        nxt.writeData = regB;                       // Store data after forwarding
        nxt.rd        = id.rd;
        nxt.memRead   = id.ctrl.memRead;
        nxt.memWrite  = id.ctrl.memWrite;
        nxt.memToReg  = id.ctrl.memToReg;
        nxt.regWrite  = id.ctrl.regWrite;
        clear         = taken;
    end
    return nxt;
endfunction

`endif

//--- verif/executeTb.sv
// Random-stimulus testbench for the execute unit that checks every EX/MEM field against a model
`timescale 1ns/1ns
`default_nettype none

module executeTb;

    import exPkg::*;

    `include "exModel.svh"

    localparam int TARGET_INSTRS = 2000;            // Accepted instructions per run
    localparam int RUN_TIMEOUT   = 10000;           // Cycle limit for the run loop
    localparam int RESET_TIMEOUT = 100;             // Cycle limit for reset release

    logic   clk;
    logic   reset_n;
    idExT   idEx;
    wbFwdT  memWb;
    logic   stall;
    logic   memStall;
    exMemT  exMem;
    logic   clearIfId;

    integer seed;                                   // $random state
    exMemT  modelExMem;                             // Predicted EX/MEM contents
    logic   modelClear;                             // Predicted flush pulse
    logic   holdInstr;                              // Upstream holds during stall
    int     accepted;
    int     cycles;

    executeUnit uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .idEx      (idEx),
        .memWb     (memWb),
        .stall     (stall),
        .memStall  (memStall),
        .exMem     (exMem),
        .clearIfId (clearIfId)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;                            // Release away from rising edge
    end

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // Corner values mixed with random words
    function automatic logic [31:0] pickData();
        case (randBelow(4))
            0: return 32'(randBelow(8));
            1: return randBelow(2) ? 32'hFFFF_FFFF : 32'h8000_0000;
            default: return $random(seed);
        endcase
    endfunction

    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic compareOutputs(input exMemT want, input logic wantClear);
        checkValue("exMem.enable", 32'(want.enable), 32'(exMem.enable));
        checkValue("exMem.pc", want.pc, exMem.pc);
        checkValue("exMem.aluResult", want.aluResult, exMem.aluResult);
        checkValue("exMem.writeData", want.writeData, exMem.writeData);
        checkValue("exMem.rd", 32'(want.rd), 32'(exMem.rd));
        checkValue("exMem.memRead", 32'(want.memRead), 32'(exMem.memRead));
        checkValue("exMem.memWrite", 32'(want.memWrite), 32'(exMem.memWrite));
        checkValue("exMem.memToReg", 32'(want.memToReg), 32'(exMem.memToReg));
        checkValue("exMem.regWrite", 32'(want.regWrite), 32'(exMem.regWrite));
        checkValue("clearIfId", 32'(wantClear), 32'(clearIfId));
    endtask

    // One legal instruction with registers from x0..x3 so hazards are common
    task automatic genInstr(output idExT ins);
        logic [11:0] imm12;
        logic [2:0]  f3;
        ins           = '0;
        ins.enable    = (randBelow(100) < 85);
        ins.pc        = $random(seed);
        ins.pc[1:0]   = 2'b00;
        ins.readData1 = pickData();
        ins.readData2 = pickData();
        ins.rs1       = 5'(randBelow(4));
        ins.rs2       = 5'(randBelow(4));
        ins.rd        = 5'(randBelow(4));
        ins.funct7    = 7'(randBelow(128));         // Ignored outside R and I types
        imm12         = 12'(randBelow(4096));
        f3            = 3'(randBelow(8));
        case (randBelow(6))
            0: begin                                // R-type
                ins.funct3        = f3;
                ins.funct7        = ((f3 == 3'b000 || f3 == 3'b101) && randBelow(2)) ? 7'h20 : 7'h00;
                ins.ctrl.aluOp    = regType;
                ins.ctrl.regWrite = 1'b1;
            end
            1: begin                                // I-type where funct7 is imm[11:5]
                if (f3 == 3'b001) imm12[11:5] = 7'h00;
                if (f3 == 3'b101) imm12[11:5] = randBelow(2) ? 7'h20 : 7'h00;
                ins.funct3        = f3;
                ins.funct7        = imm12[11:5];
                ins.ctrl.aluOp    = immType;
                ins.ctrl.aluSrc   = 1'b1;
                ins.ctrl.regWrite = 1'b1;
            end
            2: begin                                // Load word
                ins.funct3        = 3'b010;
                ins.ctrl.aluOp    = memAdd;
                ins.ctrl.aluSrc   = 1'b1;
                ins.ctrl.memRead  = 1'b1;
                ins.ctrl.memToReg = 1'b1;
                ins.ctrl.regWrite = 1'b1;
            end
            3: begin                                // Store word
                ins.funct3        = 3'b010;
                ins.ctrl.aluOp    = memAdd;
                ins.ctrl.aluSrc   = 1'b1;
                ins.ctrl.memWrite = 1'b1;
            end
            4: begin                                // BEQ or BNE
                ins.funct3      = randBelow(2) ? FUNCT3_BNE : FUNCT3_BEQ;
                ins.ctrl.aluOp  = branchSub;
                ins.ctrl.branch = 1'b1;
                if (randBelow(2)) ins.readData2 = ins.readData1; // Equal operands often
            end
            default: begin                          // JAL
                ins.ctrl.aluOp    = memAdd;
                ins.ctrl.aluSrc   = 1'b1;
                ins.ctrl.jump     = 1'b1;
                ins.ctrl.regWrite = 1'b1;
            end
        endcase
        ins.immediate = {{20{imm12[11]}}, imm12};
    endtask

    initial begin
        int waitCycles;
        seed       = 32'h8663;
        idEx       = '0;
        memWb      = '0;
        stall      = 1'b0;
        memStall   = 1'b0;
        modelExMem = '0;                            // Reset state
        modelClear = 1'b0;
        holdInstr  = 1'b0;
        accepted   = 0;
        cycles     = 0;
        waitCycles = 0;
        while (reset_n !== 1'b1) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > RESET_TIMEOUT) begin
                $display("timeout: reset was never released");
                stopWithFailure();
            end
        end
        while (accepted < TARGET_INSTRS) begin
            @(negedge clk);
            compareOutputs(modelExMem, modelClear);
            if (!holdInstr) genInstr(idEx);         // Held instruction stays stable
            stall          = (randBelow(100) < 12);
            memStall       = stall && randBelow(2);
            memWb.regWrite = randBelow(2);
            memWb.rd       = 5'(randBelow(4));
            memWb.data     = $random(seed);
            if (idEx.enable && !stall) accepted++;
            modelExMem = stepModel(idEx, memWb, stall, memStall, modelExMem, modelClear);
            holdInstr  = stall;
            cycles++;
            if (cycles >= RUN_TIMEOUT) begin
                $display("timeout: run loop did not reach the instruction count in time");
                stopWithFailure();
            end
        end
        @(negedge clk);
        compareOutputs(modelExMem, modelClear);     // Last accepted instruction
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
hdl/exPkg.sv
hdl/aluDecoder.sv
hdl/alu.sv
hdl/forwardUnit.sv
hdl/exStage.sv
hdl/executeUnit.sv
verif/executeTb.sv

//--- Bender.yml
package:
  name: execute_unit

sources:
  # RTL in compile order
  - files:
      - hdl/exPkg.sv
      - hdl/aluDecoder.sv
      - hdl/alu.sv
      - hdl/forwardUnit.sv
      - hdl/exStage.sv
      - hdl/executeUnit.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - verif
    files:
      - verif/executeTb.sv
